/* vlog.f */
source/ntm_scalar_pkg.sv
source/ntm_scalar_integer_divider.sv
source/ntm_scalar_integer_multiplier.sv
source/ntm_scalar_command_unit.sv
source/ntm_scalar_integer_alu.sv
tests/ntm_scalar_sva.sv
tests/ntm_scalar_tb.sv

/* Makefile */
# Verilator build for the scalar integer unit
# Override on the command line, e.g. make sim SEED=7

TOP       ?= ntm_scalar_tb
SEED      ?= 46
FLAGS     ?=
VERILATOR ?= verilator
OBJ_DIR   ?= obj_dir
FILELIST  := vlog.f
SOURCES   := $(wildcard source/*.sv tests/*.sv)
BINARY    := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert $(FLAGS) \
	  -f $(FILELIST) --top-module $(TOP)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary --timing --assert $(FLAGS) -GSEED=$(SEED) \
	  -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# Exit status of the binary is the pass or fail result
sim: $(BINARY)
	./$(BINARY)

clean:
	rm -rf $(OBJ_DIR)

/* tests/ntm_scalar_tb.sv */
// Testbench for the scalar integer unit, DATA_SIZE fixed at 32
// Random commands from a fixed seed, checked against a reference model
// Every command holds req for 0 to 5 extra cycles after ack

`timescale 1ns/1ps

module ntm_scalar_tb #(
  parameter int SEED = 46
);

  import ntm_scalar_pkg::*;

  localparam int DATA_SIZE      = 32;
  localparam int NUM_COMMANDS   = 400;
  localparam int TIMEOUT_CYCLES = NUM_COMMANDS * (DATA_SIZE + 8);
  // Worst single wait, unit latency plus handshake slack
  localparam int ACK_LIMIT      = DATA_SIZE + 16;

  logic                 CLK;
  logic                 RST;
  logic                 req;
  scalar_op_t           op;
  logic [DATA_SIZE-1:0] data_a;
  logic [DATA_SIZE-1:0] data_b;
  logic                 ack;
  logic [DATA_SIZE-1:0] data_out;
  logic [DATA_SIZE-1:0] rest_out;
  scalar_flags_t        flags;

  int cycle_count = 0;

  ntm_scalar_integer_alu #(
    .DATA_SIZE(DATA_SIZE)
  ) DUT (
    .CLK      (CLK),
    .RST      (RST),
    .req      (req),
    .op       (op),
    .data_a   (data_a),
    .data_b   (data_b),
    .ack      (ack),
    .data_out (data_out),
    .rest_out (rest_out),
    .flags    (flags)
  );

  ////////////////////////////////////////////////////////////
  // Clock and run limit
  ////////////////////////////////////////////////////////////

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: run went past %0d cycles", TIMEOUT_CYCLES);
      $display("SIMULATION FAILED");
      $fatal(1, "run limit reached");
    end
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [DATA_SIZE-1:0] expected,
                             input logic [DATA_SIZE-1:0] actual);
    if (actual !== expected) begin
      $display("FAILED %s: expected %h, actual %h", name, expected, actual);
      $display("SIMULATION FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // Poll ack once per cycle, 1 ns after the edge
  task automatic wait_ack(input logic level, input string name);
    int waited;
    waited = 0;
    while (ack !== level) begin
      @(posedge CLK);
      #1;
      waited++;
      if (waited > ACK_LIMIT) begin
        $display("Error in %s: ack did not reach %0b within %0d cycles",
                 name, level, ACK_LIMIT);
        $display("SIMULATION FAILED");
        $fatal(1, "handshake stalled");
      end
    end
  endtask

  function automatic logic [DATA_SIZE-1:0] random_data();
    return DATA_SIZE'($urandom);
  endfunction

  // Reference model from the opcode rules
  task automatic predict(input scalar_op_t cmd, input logic [DATA_SIZE-1:0] a,
                         input logic [DATA_SIZE-1:0] b,
                         output logic [DATA_SIZE-1:0] exp_out,
                         output logic [DATA_SIZE-1:0] exp_rest,
                         output scalar_flags_t exp_flags);
    logic [2*DATA_SIZE-1:0] product;
    product   = {{DATA_SIZE{1'b0}}, a} * {{DATA_SIZE{1'b0}}, b};
    exp_rest  = '0;
    exp_flags = '0;
    case (cmd)
      ADD: exp_out = a + b;
      SUB: exp_out = a - b;
      MUL: begin
        exp_out                = product[DATA_SIZE-1:0];
        exp_flags.mul_overflow = (product[2*DATA_SIZE-1:DATA_SIZE] != '0);
      end
      DIV: begin
        exp_flags.div_zero = (b == '0);
        exp_out            = (b == '0) ? '1 : a / b;
        exp_rest           = (b == '0) ? a : a % b;
      end
      MOD: begin
        // Remainder only, on data_out
        exp_flags.div_zero = (b == '0);
        exp_out            = (b == '0) ? a : a % b;
      end
      default: exp_out = '0;
    endcase
    exp_flags.zero = (exp_out == '0);
  endtask

  // One full four-phase transaction with result and hold checks
  task automatic run_command(input string name, input scalar_op_t cmd,
                             input logic [DATA_SIZE-1:0] a,
                             input logic [DATA_SIZE-1:0] b);
    logic [DATA_SIZE-1:0] exp_out;
    logic [DATA_SIZE-1:0] exp_rest;
    scalar_flags_t        exp_flags;
    int                   hold;
    predict(cmd, a, b, exp_out, exp_rest, exp_flags);
    hold = $urandom_range(5, 0);
    @(posedge CLK);
    #1;
    req    = 1'b1;
    op     = cmd;
    data_a = a;
    data_b = b;
    wait_ack(1'b1, name);
    check_value({name, " data_out"}, exp_out, data_out);
    check_value({name, " rest_out"}, exp_rest, rest_out);
    check_value({name, " flags"}, DATA_SIZE'(exp_flags), DATA_SIZE'(flags));
    if (cmd == DIV && b != '0) begin
      // Division identity on the DUT outputs
      check_value({name, " identity"}, a, DATA_SIZE'(data_out * b + rest_out));
      check_value({name, " rest below divisor"}, 1, DATA_SIZE'(rest_out < b));
    end
    // Host stalls, result must stay put
    repeat (hold) begin
      @(posedge CLK);
      #1;
      check_value({name, " held ack"}, 1, DATA_SIZE'(ack));
      check_value({name, " held data_out"}, exp_out, data_out);
      check_value({name, " held rest_out"}, exp_rest, rest_out);
      check_value({name, " held flags"}, DATA_SIZE'(exp_flags), DATA_SIZE'(flags));
    end
    req = 1'b0;
    wait_ack(1'b0, name);
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    scalar_op_t           cmd;
    logic [DATA_SIZE-1:0] a;
    logic [DATA_SIZE-1:0] b;
    void'($urandom(SEED));
    RST    = 1'b1;
    req    = 1'b0;
    op     = ADD;
    data_a = '0;
    data_b = '0;
    repeat (4) @(posedge CLK);
    #1;
    RST = 1'b0;

    // Reset state
    check_value("reset ack", 0, DATA_SIZE'(ack));
    check_value("reset data_out", 0, data_out);
    check_value("reset rest_out", 0, rest_out);
    check_value("reset flags", 0, DATA_SIZE'(flags));

    // ADD and SUB, zero results first
    a = random_data();
    run_command("add wrap to zero", ADD, '1, DATA_SIZE'(1));
    run_command("add negated", ADD, a, -a);
    run_command("sub equal", SUB, a, a);
    for (int i = 0; i < 97; i++) begin
      cmd = ($urandom_range(1, 0) == 0) ? ADD : SUB;
      a   = random_data();
      b   = ($urandom_range(9, 0) == 0) ? a : random_data();
      run_command("add/sub random", cmd, a, b);
    end

    // MUL, small, zero and overflow corners
    run_command("mul small", MUL, DATA_SIZE'(3), DATA_SIZE'(7));
    run_command("mul all ones", MUL, '1, '1);
    run_command("mul by zero", MUL, '0, random_data());
    run_command("mul half squared", MUL, DATA_SIZE'(1) << (DATA_SIZE / 2),
                DATA_SIZE'(1) << (DATA_SIZE / 2));
    for (int i = 0; i < 96; i++) begin
      // Mix of widths so both overflow outcomes show up
      case ($urandom_range(2, 0))
        0: begin
          a = random_data();
          b = random_data();
        end
        1: begin
          a = random_data() >> (DATA_SIZE / 2);
          b = random_data() >> (DATA_SIZE / 2);
        end
        default: begin
          a = random_data() >> (DATA_SIZE - 8);
          b = random_data();
        end
      endcase
      run_command("mul random", MUL, a, b);
    end

    // DIV and MOD corners
    a = random_data();
    run_command("div by one", DIV, a, DATA_SIZE'(1));
    run_command("div by self", DIV, a, a);
    run_command("mod by self", MOD, a, a);
    run_command("div larger divisor", DIV, a >> 4, a | DATA_SIZE'(1));
    run_command("mod larger divisor", MOD, a >> 4, a | DATA_SIZE'(1));
    run_command("mod by one", MOD, a, DATA_SIZE'(1));
    for (int i = 0; i < 144; i++) begin
      cmd = ($urandom_range(1, 0) == 0) ? DIV : MOD;
      a   = random_data();
      b   = random_data() >> $urandom_range(DATA_SIZE - 1, 0);
      run_command("div/mod random", cmd, a, b);
    end

    // Zero divisor
    run_command("div zero divisor", DIV, random_data(), '0);
    run_command("mod zero divisor", MOD, random_data(), '0);
    run_command("div zero by zero", DIV, '0, '0);
    run_command("mod zero by zero", MOD, '0, '0);

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

/* tests/ntm_scalar_sva.sv */
// Handshake and flag assertions for the scalar unit top level
// Bound to every instance of the top; inactive during reset

`timescale 1ns/1ps

module ntm_scalar_sva #(
  parameter int DATA_SIZE = 32
) (
  input logic                          CLK,
  input logic                          RST,
  input logic                          req,
  input ntm_scalar_pkg::scalar_op_t    op,
  input logic [DATA_SIZE-1:0]          data_b,
  input logic                          ack,
  input logic [DATA_SIZE-1:0]          data_out,
  input logic [DATA_SIZE-1:0]          rest_out,
  input ntm_scalar_pkg::scalar_flags_t flags
);

  import ntm_scalar_pkg::*;

  ////////////////////////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////////////////////////

  // req seen on the edge that raised ack, host may drop it right after
  ack_needs_req: assert property (@(posedge CLK) disable iff (RST)
    $rose(ack) |-> $past(req))
    else $error("ack rose while req was low");

  // Released only after the host lets go
  ack_held_until_drop: assert property (@(posedge CLK) disable iff (RST)
    ack && req |=> ack)
    else $error("ack fell while req was still high");

  result_stable: assert property (@(posedge CLK) disable iff (RST)
    ack && $past(ack) |-> $stable(data_out) && $stable(rest_out) && $stable(flags))
    else $error("outputs changed while ack was high");

  ////////////////////////////////////////////////////////////
  // Flags
  ////////////////////////////////////////////////////////////

  // Command still held by the host when ack rises
  div_zero_source: assert property (@(posedge CLK) disable iff (RST)
    $rose(ack) && flags.div_zero |-> (op == DIV || op == MOD) && data_b == '0)
    else $error("div_zero set without a zero divisor");

endmodule

bind ntm_scalar_integer_alu ntm_scalar_sva #(
  .DATA_SIZE(DATA_SIZE)
) u_sva (
  .CLK      (CLK),
  .RST      (RST),
  .req      (req),
  .op       (op),
  .data_b   (data_b),
  .ack      (ack),
  .data_out (data_out),
  .rest_out (rest_out),
  .flags    (flags)
);

/* source/ntm_scalar_integer_alu.sv */
// Scalar integer unit top level
// One command at a time over req/ack; latency depends on the opcode
// DATA_SIZE is set here and passed to every block

`timescale 1ns/1ps

module ntm_scalar_integer_alu #(
  parameter int DATA_SIZE = 32
) (
  input  logic                          CLK,
  input  logic                          RST,
  input  logic                          req,
  input  ntm_scalar_pkg::scalar_op_t    op,
  input  logic [DATA_SIZE-1:0]          data_a,
  input  logic [DATA_SIZE-1:0]          data_b,
  output logic                          ack,
  output logic [DATA_SIZE-1:0]          data_out,
  output logic [DATA_SIZE-1:0]          rest_out,
  output ntm_scalar_pkg::scalar_flags_t flags
);

  ////////////////////////////////////////////////////////////
  // Internal links
  ////////////////////////////////////////////////////////////

  logic                 mul_start;
  logic                 div_start;
  logic [DATA_SIZE-1:0] unit_a;
  logic [DATA_SIZE-1:0] unit_b;
  logic                 mul_done;
  logic [DATA_SIZE-1:0] product_low;
  logic [DATA_SIZE-1:0] product_high;
  logic                 div_done;
  logic [DATA_SIZE-1:0] quotient;
  logic [DATA_SIZE-1:0] rest;

  // Sequencer, ADD and SUB, result and flags
  ntm_scalar_command_unit #(
    .DATA_SIZE(DATA_SIZE)
  ) u_command_unit (
    .CLK          (CLK),
    .RST          (RST),
    .req          (req),
    .op           (op),
    .data_a       (data_a),
    .data_b       (data_b),
    .ack          (ack),
    .data_out     (data_out),
    .rest_out     (rest_out),
    .flags        (flags),
    .mul_start    (mul_start),
    .div_start    (div_start),
    .unit_a       (unit_a),
    .unit_b       (unit_b),
    .mul_done     (mul_done),
    .product_low  (product_low),
    .product_high (product_high),
    .div_done     (div_done),
    .quotient     (quotient),
    .rest         (rest)
  );

  ntm_scalar_integer_multiplier #(
    .DATA_SIZE(DATA_SIZE)
  ) u_multiplier (
    .CLK          (CLK),
    .RST          (RST),
    .start        (mul_start),
    .multiplicand (unit_a),
    .multiplier   (unit_b),
    .done         (mul_done),
    .product_low  (product_low),
    .product_high (product_high)
  );

  // DIV and MOD share the divider
  ntm_scalar_integer_divider #(
    .DATA_SIZE(DATA_SIZE)
  ) u_divider (
    .CLK      (CLK),
    .RST      (RST),
    .start    (div_start),
    .dividend (unit_a),
    .divisor  (unit_b),
    .done     (div_done),
    .quotient (quotient),
    .rest     (rest)
  );

endmodule

/* source/ntm_scalar_command_unit.sv */
// Command register and sequencer for the scalar unit
// Host must follow the four-phase req/ack rules, one command in flight
// ADD and SUB wrap; zero divisor is resolved here without the divider

`timescale 1ns/1ps

module ntm_scalar_command_unit #(
  parameter int DATA_SIZE = 32
) (
  input  logic                         CLK,
  input  logic                         RST,
  // Host side
  input  logic                         req,
  input  ntm_scalar_pkg::scalar_op_t   op,
  input  logic [DATA_SIZE-1:0]         data_a,
  input  logic [DATA_SIZE-1:0]         data_b,
  output logic                         ack,
  output logic [DATA_SIZE-1:0]         data_out,
  output logic [DATA_SIZE-1:0]         rest_out,
  output ntm_scalar_pkg::scalar_flags_t flags,
  // Arithmetic block side
  output logic                         mul_start,
  output logic                         div_start,
  output logic [DATA_SIZE-1:0]         unit_a,
  output logic [DATA_SIZE-1:0]         unit_b,
  input  logic                         mul_done,
  input  logic [DATA_SIZE-1:0]         product_low,
  input  logic [DATA_SIZE-1:0]         product_high,
  input  logic                         div_done,
  input  logic [DATA_SIZE-1:0]         quotient,
  input  logic [DATA_SIZE-1:0]         rest
);

  import ntm_scalar_pkg::*;

  command_state_t       state;
  scalar_op_t           op_q;
  logic [DATA_SIZE-1:0] a_q;
  logic [DATA_SIZE-1:0] b_q;
  logic                 res_ready;   // Result loaded, ack goes up next edge
  logic                 b_zero;
  logic                 local_op;    // Finished here without a block
  logic                 unit_done;
  logic [DATA_SIZE-1:0] res_d;
  logic [DATA_SIZE-1:0] rest_d;
  scalar_flags_t        flags_d;

  // Both blocks share the latched operands
  assign unit_a    = a_q;
  assign unit_b    = b_q;
  assign b_zero    = (b_q == '0);
  assign unit_done = (op_q == MUL) ? mul_done : div_done;

  ////////////////////////////////////////////////////////////
  // Result formation
  ////////////////////////////////////////////////////////////

  always_comb begin
    res_d    = '0;
    rest_d   = '0;
    flags_d  = '0;
    local_op = 1'b1;
    case (op_q)
      ADD: res_d = a_q + b_q;
      SUB: res_d = a_q - b_q;
      MUL: begin
        local_op             = 1'b0;
        res_d                = product_low;
        flags_d.mul_overflow = |product_high;
      end
      DIV: begin
        local_op         = b_zero;
        flags_d.div_zero = b_zero;
        res_d            = b_zero ? '1 : quotient;
        rest_d           = b_zero ? a_q : rest;
      end
      MOD: begin
        // Remainder goes on data_out, rest_out stays zero
        local_op         = b_zero;
        flags_d.div_zero = b_zero;
        res_d            = b_zero ? a_q : rest;
      end
      default: begin
      end
    endcase
    flags_d.zero = (res_d == '0);
  end

  ////////////////////////////////////////////////////////////
  // Handshake sequencer
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= WAIT_REQ;
      ack       <= 1'b0;
      mul_start <= 1'b0;
      div_start <= 1'b0;
      res_ready <= 1'b0;
      data_out  <= '0;
      rest_out  <= '0;
      flags     <= '0;
    end else begin
      mul_start <= 1'b0;
      div_start <= 1'b0;
      case (state)
        WAIT_REQ: begin
          if (req) begin
            state <= EXECUTE;
          end
        end
        EXECUTE: begin
          // ADD, SUB and zero divisor load the result now
          if (local_op) begin
            data_out  <= res_d;
            rest_out  <= rest_d;
            flags     <= flags_d;
            res_ready <= 1'b1;
          end else if (op_q == MUL) begin
            mul_start <= 1'b1;
          end else begin
            div_start <= 1'b1;
          end
          state <= WAIT_UNIT;
        end
        WAIT_UNIT: begin
          if (res_ready) begin
            ack       <= 1'b1;
            res_ready <= 1'b0;
            state     <= HOLD_ACK;
          end else if (unit_done) begin
            data_out  <= res_d;
            rest_out  <= rest_d;
            flags     <= flags_d;
            res_ready <= 1'b1;
          end
        end
        HOLD_ACK: begin
          // Outputs frozen until the host drops req
          if (!req) begin
            ack   <= 1'b0;
            state <= WAIT_REQ;
          end
        end
        default: begin
          state <= WAIT_REQ;
        end
      endcase
    end
  end

  // Command latch
  always_ff @(posedge CLK) begin
    if (state == WAIT_REQ && req) begin
      op_q <= op;
      a_q  <= data_a;
      b_q  <= data_b;
    end
  end

endmodule

/* source/ntm_scalar_integer_multiplier.sv */
// Shift-add unsigned multiplier, one multiplier bit per cycle
// Same timing as the divider: done follows start by DATA_SIZE+1 cycles
// Full product is split into product_high and product_low

`timescale 1ns/1ps

module ntm_scalar_integer_multiplier #(
  parameter int DATA_SIZE = 32
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 start,
  input  logic [DATA_SIZE-1:0] multiplicand,
  input  logic [DATA_SIZE-1:0] multiplier,
  output logic                 done,
  output logic [DATA_SIZE-1:0] product_low,
  output logic [DATA_SIZE-1:0] product_high
);

  import ntm_scalar_pkg::*;

  localparam int CNT_W = (DATA_SIZE > 1) ? $clog2(DATA_SIZE) : 1;
  localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(DATA_SIZE - 1);

  divider_state_t         state;
  logic [CNT_W-1:0]       step_cnt;
  logic [DATA_SIZE-1:0]   mcand_q;

  // Upper half collects partial sums, lower half holds unused multiplier bits
  logic [2*DATA_SIZE-1:0] acc;
  logic [DATA_SIZE:0]     partial_sum;

  ////////////////////////////////////////////////////////////
  // Add step
  ////////////////////////////////////////////////////////////

  // Carry kept in the top bit, shifted back in on the right shift
  assign partial_sum = {1'b0, acc[2*DATA_SIZE-1:DATA_SIZE]}
                     + (acc[0] ? {1'b0, mcand_q} : '0);

  ////////////////////////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state    <= IDLE;
      step_cnt <= '0;
      done     <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        IDLE: begin
          if (start) begin
            step_cnt <= '0;
            state    <= SHIFT;
          end
        end
        SHIFT: begin
          step_cnt <= step_cnt + 1'b1;
          if (step_cnt == LAST_STEP) begin
            state <= DONE;
          end
        end
        DONE: begin
          done  <= 1'b1;
          state <= IDLE;
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // Accumulator and result registers
  always_ff @(posedge CLK) begin
    case (state)
      IDLE: begin
        if (start) begin
          acc     <= {{DATA_SIZE{1'b0}}, multiplier};
          mcand_q <= multiplicand;
        end
      end
      SHIFT: begin
        acc <= {partial_sum, acc[DATA_SIZE-1:1]};
      end
      DONE: begin
        product_high <= acc[2*DATA_SIZE-1:DATA_SIZE];
        product_low  <= acc[DATA_SIZE-1:0];
      end
      default: begin
      end
    endcase
  end

endmodule

/* source/ntm_scalar_integer_divider.sv */
// Restoring unsigned divider, one quotient bit per cycle
// start is taken only in IDLE; done follows start by DATA_SIZE+1 cycles
// A zero divisor yields all-ones quotient and rest equal to the dividend
// DATA_SIZE must be at least 2

`timescale 1ns/1ps

module ntm_scalar_integer_divider #(
  parameter int DATA_SIZE = 32
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 start,
  input  logic [DATA_SIZE-1:0] dividend,
  input  logic [DATA_SIZE-1:0] divisor,
  output logic                 done,
  output logic [DATA_SIZE-1:0] quotient,
  output logic [DATA_SIZE-1:0] rest
);

  import ntm_scalar_pkg::*;

  ////////////////////////////////////////////////////////////
  // Declarations
  ////////////////////////////////////////////////////////////

  localparam int CNT_W = (DATA_SIZE > 1) ? $clog2(DATA_SIZE) : 1;
  localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(DATA_SIZE - 1);

  divider_state_t       state;
  logic [CNT_W-1:0]     step_cnt;

  // Dividend shifts out at the top, quotient bits shift in at the bottom
  logic [DATA_SIZE-1:0] quo_shift;
  logic [DATA_SIZE-1:0] rem_part;
  logic [DATA_SIZE-1:0] divisor_q;

  // One extra bit so the shifted remainder never overflows
  logic [DATA_SIZE:0]   rem_shifted;
  logic [DATA_SIZE:0]   rem_trial;
  logic                 fits;

  ////////////////////////////////////////////////////////////
  // Step datapath
  ////////////////////////////////////////////////////////////

  // Bring down next dividend bit
  assign rem_shifted = {rem_part, quo_shift[DATA_SIZE-1]};
  assign rem_trial   = rem_shifted - {1'b0, divisor_q};

  // Restore when the trial subtraction would go negative
  assign fits = (rem_shifted >= {1'b0, divisor_q});

  ////////////////////////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state    <= IDLE;
      step_cnt <= '0;
      done     <= 1'b0;
    end else begin
      // done is a single-cycle pulse
      done <= 1'b0;
      case (state)
        IDLE: begin
          if (start) begin
            step_cnt <= '0;
            state    <= SHIFT;
          end
        end
        SHIFT: begin
          step_cnt <= step_cnt + 1'b1;
          // DATA_SIZE steps, counted 0 to DATA_SIZE-1
          if (step_cnt == LAST_STEP) begin
            state <= DONE;
          end
        end
        DONE: begin
          done  <= 1'b1;
          state <= IDLE;
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // Operand and result registers
  always_ff @(posedge CLK) begin
    case (state)
      IDLE: begin
        if (start) begin
          quo_shift <= dividend;
          rem_part  <= '0;
          divisor_q <= divisor;
        end
      end
      SHIFT: begin
        quo_shift <= {quo_shift[DATA_SIZE-2:0], fits};
        rem_part  <= fits ? rem_trial[DATA_SIZE-1:0] : rem_shifted[DATA_SIZE-1:0];
      end
      DONE: begin
        // Outputs change only here, stable until the next run
        quotient <= quo_shift;
        rest     <= rem_part;
      end
      default: begin
      end
    endcase
  end

endmodule

/* source/ntm_scalar_pkg.sv */
// Shared types for the scalar integer unit
// Operands are unsigned and the data width is a module parameter, so only
// opcodes, flags and FSM states live here

package ntm_scalar_pkg;

  ////////////////////////////////////////////////////////////
  // Opcodes
  ////////////////////////////////////////////////////////////

  // Host command encoding, 3 bits on the bus
  typedef enum logic [2:0] {
    ADD = 3'd0,
    SUB = 3'd1,
    MUL = 3'd2,
    DIV = 3'd3,
    MOD = 3'd4
  } scalar_op_t;

  ////////////////////////////////////////////////////////////
  // Result flags
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic div_zero;      // DIV or MOD with a zero divisor
    logic mul_overflow;  // High half of the product non-zero
    logic zero;          // data_out is zero
  } scalar_flags_t;

  ////////////////////////////////////////////////////////////
  // FSM states
  ////////////////////////////////////////////////////////////

  // Step sequencer shared by divider and multiplier
  typedef enum logic [1:0] {
    IDLE,
    SHIFT,
    DONE
  } divider_state_t;

  // Command unit handshake sequencer
  typedef enum logic [1:0] {
    WAIT_REQ,
    EXECUTE,
    WAIT_UNIT,
    HOLD_ACK
  } command_state_t;

endpackage
